// ==== verilog/cu_setup_pkg.sv ====
// Setup stage package with address, data and count types, word size and FIFO sizing
package cu_setup_pkg;

    // -------------------------------------------------------------------------
    // Bus widths
    // -------------------------------------------------------------------------

    // Byte address of one memory word
    localparam int ADDR_W = 32;

    // One memory response word
    localparam int DATA_W = 64;

    // Word count carried by a descriptor
    localparam int COUNT_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [COUNT_W-1:0] count_t;

    // -------------------------------------------------------------------------
    // Memory layout
    // -------------------------------------------------------------------------

    // Bytes per memory word, also the step between two consecutive requests
    localparam int WORD_BYTES = 8;

    // -------------------------------------------------------------------------
    // FIFO sizing
    // -------------------------------------------------------------------------

    // Entries per FIFO, same for request and response paths
    localparam int FIFO_DEPTH = 32;

    // Fill level at or above which prog_full is raised
    // Must leave headroom for the few writes in flight after a pause
    localparam int PROG_THRESH = 16;

    // Read and write pointer width
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Occupancy counter width, one more state than the pointer for full
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // -------------------------------------------------------------------------
    // Setup sequencer states
    // -------------------------------------------------------------------------

    // RESET   first cycle out of reset
    // IDLE    waiting for a registered descriptor
    // START   engine load, held until the engine leaves done
    // BUSY    addresses are being generated
    // PAUSE   generation held while a FIFO is past its threshold
    // DONE    all requests generated and drained
    typedef enum logic [2:0] {
        RESET = 3'd0,
        IDLE  = 3'd1,
        START = 3'd2,
        BUSY  = 3'd3,
        PAUSE = 3'd4,
        DONE  = 3'd5
    } setup_state_t;

endpackage

// ==== verilog/packet_fifo.sv ====
// Packet FIFO, synchronous circular buffer with registered pop and programmable full
`timescale 1ns/10ps

module packet_fifo #(
    parameter type payload_t = cu_setup_pkg::addr_t
) (
    input  logic     ap_clk,
    input  logic     areset_cu_setup,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     valid,
    output logic     empty,
    output logic     prog_full
);
    import cu_setup_pkg::*;

    // Pointer advance with wrap at the last entry
    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fill;
    logic                  full;
    logic                  do_write;
    logic                  do_read;

    // -------------------------------------------------------------------------
    // Fill state
    // -------------------------------------------------------------------------
    assign full      = (fill == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty     = (fill == '0);
    assign prog_full = (fill >= FIFO_CNT_W'(PROG_THRESH));

    // Writes into a full buffer are dropped, reads from an empty one ignored
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    // -------------------------------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // dout is valid the cycle after the pop
            valid <= do_read;
        end
    end

    // -------------------------------------------------------------------------
    // Storage and registered read port
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== verilog/read_request_engine.sv ====
// Serial read engine, expands a base address and word count into word addresses
`timescale 1ns/10ps

module read_request_engine (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 start,
    input  logic                 run,
    input  cu_setup_pkg::addr_t  base,
    input  cu_setup_pkg::count_t count,
    output logic                 gen_valid,
    output cu_setup_pkg::addr_t  gen_addr,
    output logic                 gen_done
);
    import cu_setup_pkg::*;

    // Address of the next word to request
    addr_t  next_addr;

    // Words still to be generated
    count_t remaining;

    logic   last_word;

    // -------------------------------------------------------------------------
    // Request output
    // -------------------------------------------------------------------------

    // One address per cycle while running and words remain.
    // The FIFO takes gen_valid and gen_addr as write enable and write data
    assign gen_valid = run & ~start & (remaining != '0);
    assign gen_addr  = next_addr;

    // Last word leaves this cycle
    assign last_word = gen_valid & (remaining == count_t'(1));

    // -------------------------------------------------------------------------
    // Word counter and done flag
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            remaining <= '0;
            gen_done  <= 1'b1;
        end else if (start) begin
            remaining <= count;
            // Nothing to do for an empty descriptor
            gen_done  <= (count == '0);
        end else if (gen_valid) begin
            remaining <= remaining - count_t'(1);
            if (last_word) begin
                gen_done <= 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Address stepping
    // -------------------------------------------------------------------------

    // Fixed stride of one word
    always_ff @(posedge ap_clk) begin
        if (start) begin
            next_addr <= base;
        end else if (gen_valid) begin
            next_addr <= next_addr + addr_t'(WORD_BYTES);
        end
    end

endmodule

// ==== verilog/setup_sequencer.sv ====
// Setup sequencer, FSM that starts, pauses and completes the read request engine
`timescale 1ns/10ps

module setup_sequencer (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 descriptor_valid,
    input  cu_setup_pkg::addr_t  descriptor_base,
    input  cu_setup_pkg::count_t descriptor_count,
    input  logic                 gen_done,
    input  logic                 req_prog_full,
    input  logic                 rsp_prog_full,
    input  logic                 req_empty,
    output logic                 start,
    output logic                 run,
    output cu_setup_pkg::addr_t  base,
    output cu_setup_pkg::count_t count,
    output logic                 setup_done
);
    import cu_setup_pkg::*;

    logic         descriptor_valid_reg;
    logic         back_pressure;
    logic         drained;
    setup_state_t current_state;
    setup_state_t next_state;

    // -------------------------------------------------------------------------
    // Descriptor input register
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            descriptor_valid_reg <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid;
        end
    end

    // Base and count held stable by the source while valid is high
    always_ff @(posedge ap_clk) begin
        base  <= descriptor_base;
        count <= descriptor_count;
    end

    // Either FIFO past its threshold
    assign back_pressure = req_prog_full | rsp_prog_full;

    // Everything generated and popped by the reader
    assign drained = gen_done & req_empty;

    // -------------------------------------------------------------------------
    // State register
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            current_state <= RESET;
        end else begin
            current_state <= next_state;
        end
    end

    // -------------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (descriptor_valid_reg) begin
                    next_state = START;
                end
            end
            START: begin
                // A zero count never clears gen_done, so move on directly
                if (~gen_done || count == '0) begin
                    next_state = BUSY;
                end
            end
            BUSY: begin
                if (drained) begin
                    next_state = DONE;
                end else if (back_pressure) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (~back_pressure) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                // hold until the descriptor is withdrawn
                if (~descriptor_valid_reg) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // Engine control and completion
    // -------------------------------------------------------------------------

    // Load pulse, drops as soon as the engine leaves done
    assign start = (current_state == START) & gen_done;

    // Generation already runs in the cycle after the load
    assign run = (current_state == BUSY) | ((current_state == START) & ~gen_done);

    assign setup_done = (current_state == DONE);

endmodule

// ==== verilog/cu_setup_top.sv ====
// Compute unit setup stage top, sequencer, address engine and request and response FIFOs
`timescale 1ns/10ps

module cu_setup_top (
    input  logic                 ap_clk,
    input  logic                 areset_cu_setup,
    input  logic                 descriptor_valid,
    input  cu_setup_pkg::addr_t  descriptor_base,
    input  cu_setup_pkg::count_t descriptor_count,
    input  logic                 request_rd_en,
    output logic                 request_valid,
    output cu_setup_pkg::addr_t  request_addr,
    input  logic                 response_valid,
    input  cu_setup_pkg::data_t  response_data,
    input  logic                 response_rd_en,
    output logic                 response_out_valid,
    output cu_setup_pkg::data_t  response_out_data,
    output logic                 setup_done
);
    import cu_setup_pkg::*;

    // Sequencer to engine
    logic   seq_start;
    logic   seq_run;
    addr_t  seq_base;
    count_t seq_count;

    // Engine to request FIFO
    logic   gen_valid;
    addr_t  gen_addr;
    logic   gen_done;

    // FIFO fill state back to the sequencer
    logic   req_empty;
    logic   req_prog_full;
    logic   rsp_prog_full;

    // Registered memory response
    logic   response_valid_reg;
    data_t  response_data_reg;

    // -------------------------------------------------------------------------
    // Sequencer and address engine
    // -------------------------------------------------------------------------
    setup_sequencer sequencer (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor_base  (descriptor_base),
        .descriptor_count (descriptor_count),
        .gen_done         (gen_done),
        .req_prog_full    (req_prog_full),
        .rsp_prog_full    (rsp_prog_full),
        .req_empty        (req_empty),
        .start            (seq_start),
        .run              (seq_run),
        .base             (seq_base),
        .count            (seq_count),
        .setup_done       (setup_done)
    );

    read_request_engine engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .start           (seq_start),
        .run             (seq_run),
        .base            (seq_base),
        .count           (seq_count),
        .gen_valid       (gen_valid),
        .gen_addr        (gen_addr),
        .gen_done        (gen_done)
    );

    // -------------------------------------------------------------------------
    // Request path
    // -------------------------------------------------------------------------
    packet_fifo #(
        .payload_t (addr_t)
    ) request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .wr_en           (gen_valid),
        .din             (gen_addr),
        .rd_en           (request_rd_en),
        .dout            (request_addr),
        .valid           (request_valid),
        .empty           (req_empty),
        .prog_full       (req_prog_full)
    );

    // -------------------------------------------------------------------------
    // Response path
    // -------------------------------------------------------------------------

    // Input register ahead of the FIFO write
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_valid_reg <= 1'b0;
        end else begin
            response_valid_reg <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_data_reg <= response_data;
    end

    // Empty flag not needed here, the consumer pop is gated inside the FIFO
    packet_fifo #(
        .payload_t (data_t)
    ) response_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .wr_en           (response_valid_reg),
        .din             (response_data_reg),
        .rd_en           (response_rd_en),
        .dout            (response_out_data),
        .valid           (response_out_valid),
        .empty           (),
        .prog_full       (rsp_prog_full)
    );

endmodule

// ==== tb/tb_cu_setup.sv ====
// Directed testbench for the compute unit setup stage, descriptor, request and response paths
`timescale 1ns/10ps

module tb_cu_setup;
    import cu_setup_pkg::*;

    localparam int WAIT_LIMIT = 400;
    localparam logic [31:0] LFSR_SEED = 32'he16b_740b;

    // Galois feedback for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic   ap_clk;
    logic   areset_cu_setup;
    logic   descriptor_valid;
    addr_t  descriptor_base;
    count_t descriptor_count;
    logic   request_rd_en;
    logic   request_valid;
    addr_t  request_addr;
    logic   response_valid;
    data_t  response_data;
    logic   response_rd_en;
    logic   response_out_valid;
    data_t  response_out_data;
    logic   setup_done;

    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_state;
    data_t       sent_words[$];

    cu_setup_top UUT (
        .ap_clk             (ap_clk),
        .areset_cu_setup    (areset_cu_setup),
        .descriptor_valid   (descriptor_valid),
        .descriptor_base    (descriptor_base),
        .descriptor_count   (descriptor_count),
        .request_rd_en      (request_rd_en),
        .request_valid      (request_valid),
        .request_addr       (request_addr),
        .response_valid     (response_valid),
        .response_data      (response_data),
        .response_rd_en     (response_rd_en),
        .response_out_valid (response_out_valid),
        .response_out_data  (response_out_data),
        .setup_done         (setup_done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------------------
    // Random data
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit of the word
    task automatic random_word(output data_t word);
        word = '0;
        for (int i = 0; i < DATA_W; i++) begin
            word = {word[DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks and reporting
    // ------------------------------------------------------------------------
    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        errors++;
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        end
    endtask

    // ------------------------------------------------------------------------
    // Descriptor and request helpers
    // ------------------------------------------------------------------------
    task automatic raise_descriptor(input addr_t first, input count_t words);
        @(negedge ap_clk);
        descriptor_valid = 1'b1;
        descriptor_base  = first;
        descriptor_count = words;
    endtask

    task automatic wait_setup_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (setup_done !== level && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (setup_done !== level) begin
            report_timeout(what);
        end
    endtask

    task automatic release_descriptor();
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        wait_setup_done(1'b0, "setup_done to fall");
    endtask

    // Pops until the given number of words has arrived, checking each address
    task automatic collect_requests(input addr_t first, input int words);
        int received;
        int cycles;
        received = 0;
        cycles   = 0;
        @(negedge ap_clk);
        request_rd_en = 1'b1;
        while (received < words && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
            if (request_valid) begin
                check_addr("request_addr", request_addr,
                           first + addr_t'(received * WORD_BYTES));
                // No completion before the last pop
                check_bit("setup_done", setup_done, 1'b0);
                received++;
            end
        end
        request_rd_en = 1'b0;
        if (received < words) begin
            report_timeout("request words");
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_reset_values();
        start_test();
        check_bit("request_valid", request_valid, 1'b0);
        check_bit("response_out_valid", response_out_valid, 1'b0);
        check_bit("setup_done", setup_done, 1'b0);
        end_test("reset values");
    endtask

    task automatic test_short_descriptor();
        start_test();
        raise_descriptor(32'h0001_0000, 16'd4);
        collect_requests(32'h0001_0000, 4);
        wait_setup_done(1'b1, "setup_done");
        release_descriptor();
        end_test("four word descriptor");
    endtask

    task automatic test_back_pressure();
        start_test();
        raise_descriptor(32'h0020_0100, 16'd40);
        // Reader stalls while the FIFO fills past its threshold
        repeat (60) begin
            @(negedge ap_clk);
            check_bit("request_valid", request_valid, 1'b0);
            check_bit("setup_done", setup_done, 1'b0);
        end
        collect_requests(32'h0020_0100, 40);
        wait_setup_done(1'b1, "setup_done");
        release_descriptor();
        end_test("back-pressure");
    endtask

    task automatic test_response_order();
        data_t word;
        int    received;
        int    cycles;
        start_test();
        sent_words.delete();
        for (int i = 0; i < 20; i++) begin
            random_word(word);
            sent_words.push_back(word);
            @(negedge ap_clk);
            response_valid = 1'b1;
            response_data  = word;
        end
        @(negedge ap_clk);
        response_valid = 1'b0;
        response_data  = '0;
        response_rd_en = 1'b1;
        received = 0;
        cycles   = 0;
        while (received < 20 && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
            if (response_out_valid) begin
                check_data("response_out_data", response_out_data, sent_words[received]);
                received++;
            end
        end
        response_rd_en = 1'b0;
        if (received < 20) begin
            report_timeout("response words");
        end
        end_test("response order");
    endtask

    task automatic test_zero_count();
        int cycles;
        start_test();
        raise_descriptor(32'h0300_0000, 16'd0);
        request_rd_en = 1'b1;
        cycles = 0;
        while (setup_done !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
            check_bit("request_valid", request_valid, 1'b0);
        end
        if (setup_done !== 1'b1) begin
            report_timeout("setup_done on zero count");
        end
        release_descriptor();
        check_bit("request_valid", request_valid, 1'b0);
        request_rd_en = 1'b0;
        end_test("zero count");
    endtask

    task automatic test_done_hold();
        start_test();
        raise_descriptor(32'h0004_2000, 16'd3);
        collect_requests(32'h0004_2000, 3);
        wait_setup_done(1'b1, "setup_done");
        repeat (10) begin
            @(negedge ap_clk);
            check_bit("setup_done", setup_done, 1'b1);
        end
        release_descriptor();
        // Second descriptor after withdrawal
        raise_descriptor(32'h0008_8000, 16'd5);
        collect_requests(32'h0008_8000, 5);
        wait_setup_done(1'b1, "second setup_done");
        release_descriptor();
        end_test("done hold and second descriptor");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        areset_cu_setup  = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_count = '0;
        request_rd_en    = 1'b0;
        response_valid   = 1'b0;
        response_data    = '0;
        response_rd_en   = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        lfsr_state       = LFSR_SEED;

        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_cu_setup = 1'b0;

        test_reset_values();
        test_short_descriptor();
        test_back_pressure();
        test_response_order();
        test_zero_count();
        test_done_hold();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/cu_setup_pkg.sv
verilog/packet_fifo.sv
verilog/read_request_engine.sv
verilog/setup_sequencer.sv
verilog/cu_setup_top.sv
tb/tb_cu_setup.sv

// ==== Makefile ====
# Verilator build and run of the compute unit setup stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_cu_setup with Verilator and run it"
	@echo "  clean  remove the build directory"

obj_dir/tb_cu_setup: list.f verilog/*.sv tb/*.sv
	verilator --binary --timing -j 0 --top-module tb_cu_setup \
		-Mdir obj_dir -o tb_cu_setup -f list.f

test: obj_dir/tb_cu_setup
	@out="$$(./obj_dir/tb_cu_setup)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
